// File: all.f
logic/fetch_pkg.sv
logic/fetch_if.sv
logic/fetch_sequencer.sv
logic/instr_mem.sv
logic/fetch_buffer.sv
logic/fetch_unit.sv
dv/fetch_unit_sva.sv
dv/fetch_unit_tb.sv

// File: dv/fetch_unit_sva.sv
`timescale 1ns/1ps

module fetch_unit_sva (
  input logic clock,
  input logic reset,
  input logic issue_stall,
  input logic ready0,
  input logic ready1,
  input logic [fetch_pkg::pc_width-1:0] pc0,
  input logic [fetch_pkg::pc_width-1:0] pc1
);

  // slot 1 never runs ahead of slot 0.
  slot_order: assert property (@(posedge clock) disable iff (!reset) ready1 |-> ready0)
    else $error("slot 1 is ready while slot 0 is idle");

  idle_pc0: assert property (@(posedge clock) disable iff (!reset)
    !ready0 |-> pc0 == fetch_pkg::no_pc)
    else $error("idle slot 0 does not show the idle pc");

  idle_pc1: assert property (@(posedge clock) disable iff (!reset)
    !ready1 |-> pc1 == fetch_pkg::no_pc)
    else $error("idle slot 1 does not show the idle pc");

  // a stalled issue stage sees nothing offered.
  stall_blocks: assert property (@(posedge clock) disable iff (!reset)
    issue_stall |-> !ready0 && !ready1)
    else $error("a slot is ready while issue_stall is high");

endmodule

bind fetch_unit fetch_unit_sva fetch_unit_sva_inst (
  .clock(clock),
  .reset(reset),
  .issue_stall(issue_stall),
  .ready0(ready0),
  .ready1(ready1),
  .pc0(pc0),
  .pc1(pc1)
);

// File: dv/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

  localparam int buffer_depth = 16;
  localparam int run_cycles = 3000;
  localparam int idle_limit = 16; // cycles with no issue although nothing blocks it.
  localparam int drain_count = 200;
  localparam int drain_limit = 2000;

  logic clock;
  logic reset;
  logic run;
  logic redirect;
  logic [fetch_pkg::pc_width-1:0] redirect_pc;
  logic issue_stall;
  logic load_valid;
  logic [fetch_pkg::mem_addr_width-1:0] load_addr;
  logic [fetch_pkg::fetch_width-1:0] load_data;
  logic ready0;
  logic ready1;
  logic [fetch_pkg::pc_width-1:0] pc0;
  logic [fetch_pkg::pc_width-1:0] pc1;
  fetch_pkg::instr_word_u instr0;
  fetch_pkg::instr_word_u instr1;

  logic [fetch_pkg::fetch_width-1:0] mem_copy [fetch_pkg::mem_words];
  logic [31:0] rng_state;
  logic tracking; // set once the first redirect has started fetch.
  logic [fetch_pkg::pc_width-1:0] expected_pc;
  int issued;
  int idle_cycles;

  fetch_unit #(
    .buffer_depth(buffer_depth)
  ) fetch_unit_inst (
    .clock(clock),
    .reset(reset),
    .run(run),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .issue_stall(issue_stall),
    .load_valid(load_valid),
    .load_addr(load_addr),
    .load_data(load_data),
    .ready0(ready0),
    .ready1(ready1),
    .pc0(pc0),
    .pc1(pc1),
    .instr0(instr0),
    .instr1(instr1)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // half of all parcels come out compressed.
  function automatic fetch_pkg::parcel_t random_parcel();
    logic [31:0] r;
    fetch_pkg::parcel_t p;
    r = next_random();
    p = r[15:0];
    if (r[16]) begin
      p[1:0] = 2'b11;
    end else begin
      p[1:0] = (r[18:17] == 2'b11) ? 2'b00 : r[18:17];
    end
    return p;
  endfunction

  function automatic fetch_pkg::parcel_t parcel_at(input logic [fetch_pkg::pc_width-1:0] pc);
    logic [fetch_pkg::fetch_width-1:0] word;
    word = mem_copy[pc[8:3]]; // the memory wraps on its 64 words.
    return word[{pc[2:1], 4'b0000} +: 16];
  endfunction

  // expected instruction at pc and its length in bytes.
  function automatic fetch_pkg::instr_word_u ref_next(
    input logic [fetch_pkg::pc_width-1:0] pc,
    output logic [fetch_pkg::pc_width-1:0] length
  );
    fetch_pkg::instr_word_u word;
    fetch_pkg::parcel_t first;
    first = parcel_at(pc);
    if (first[1:0] == 2'b11) begin
      word.raw = {parcel_at(pc + 32'd2), first};
      length = 32'd4;
    end else begin
      word.raw = {16'h0000, first};
      length = 32'd2;
    end
    return word;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_pc(
    input string name,
    input logic [fetch_pkg::pc_width-1:0] expected,
    input logic [fetch_pkg::pc_width-1:0] actual
  );
    if (actual !== expected) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic check_instr(
    input string name,
    input fetch_pkg::instr_word_u expected,
    input fetch_pkg::instr_word_u actual
  );
    if (actual.raw !== expected.raw) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                  name, expected.raw, actual.raw));
    end
  endtask

  // outputs are settled at the falling edge, half a cycle after the inputs moved.
  always @(negedge clock) begin : compare
    fetch_pkg::instr_word_u exp_word;
    logic [fetch_pkg::pc_width-1:0] length;
    if (reset) begin
      if (ready1 && !ready0) begin
        stop_with_failure("slot 1 is ready while slot 0 is not");
      end
      if (!ready0) begin
        check_pc("idle pc0", fetch_pkg::no_pc, pc0);
        check_instr("idle instr0", '0, instr0);
      end
      if (!ready1) begin
        check_pc("idle pc1", fetch_pkg::no_pc, pc1);
        check_instr("idle instr1", '0, instr1);
      end
      if (issue_stall && (ready0 || ready1)) begin
        stop_with_failure("a slot is ready while issue_stall is high");
      end
      if (!tracking && (ready0 || ready1)) begin
        stop_with_failure("a slot is ready before fetch was started");
      end
      if (tracking && ready0) begin
        exp_word = ref_next(expected_pc, length);
        check_pc("slot 0 pc", expected_pc, pc0);
        check_instr("slot 0 instr", exp_word, instr0);
        expected_pc = expected_pc + length;
        issued++;
        if (ready1) begin
          exp_word = ref_next(expected_pc, length);
          check_pc("slot 1 pc", expected_pc, pc1);
          check_instr("slot 1 instr", exp_word, instr1);
          expected_pc = expected_pc + length;
          issued++;
        end
      end
      if (tracking && !issue_stall && !redirect && !ready0) begin
        idle_cycles++;
        if (idle_cycles > idle_limit) begin
          stop_with_failure("timeout: no instruction issued although nothing blocked it");
        end
      end else begin
        idle_cycles = 0;
      end
      if (redirect) begin
        tracking = 1'b1; // the stream restarts at the target.
        expected_pc = redirect_pc;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [fetch_pkg::fetch_width-1:0] word;
    int hold_left;
    int wait_cycles;
    int target;
    reset = 1'b0;
    run = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    issue_stall = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = '0;
    rng_state = 32'h7008bbd2;
    tracking = 1'b0;
    expected_pc = fetch_pkg::no_pc;
    issued = 0;
    idle_cycles = 0;
    hold_left = 0;

    repeat (8) @(posedge clock);
    reset <= 1'b1;

    for (int i = 0; i < fetch_pkg::mem_words; i++) begin
      for (int p = 0; p < 4; p++) begin
        word[16 * p +: 16] = random_parcel();
      end
      mem_copy[i] = word;
      @(posedge clock);
      load_valid <= 1'b1;
      load_addr <= fetch_pkg::mem_addr_width'(i);
      load_data <= word;
    end

    @(posedge clock);
    load_valid <= 1'b0;
    run <= 1'b1;
    redirect <= 1'b1;
    redirect_pc <= '0;

    for (int c = 0; c < run_cycles; c++) begin
      @(posedge clock);
      r = next_random();
      redirect <= 1'b0;
      if (hold_left > 0) begin
        hold_left--;
        issue_stall <= 1'b1;
      end else if (!issue_stall && r[2:0] == 3'd0) begin
        hold_left = r[7] ? int'(r[12:8]) : int'(r[10:8]); // long holds fill the queue.
        issue_stall <= 1'b1;
      end else begin
        issue_stall <= 1'b0;
      end
      if (r[18:13] == 6'd0) begin
        redirect <= 1'b1;
        redirect_pc <= fetch_pkg::pc_width'({r[24:19], 3'b000});
      end
    end

    @(posedge clock);
    redirect <= 1'b0;
    issue_stall <= 1'b0;
    target = issued + drain_count;
    wait_cycles = 0;
    while (issued < target) begin
      if (wait_cycles == drain_limit) begin
        stop_with_failure("timeout: the stream stopped issuing after the random phase");
      end
      @(posedge clock);
      wait_cycles++;
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: logic/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer #(
  parameter int buffer_depth = 16
) (
  input logic clock,
  input logic reset,
  fetch_if.buffer fetch,
  input logic issue_stall,
  output logic ready0,
  output logic ready1,
  output logic [fetch_pkg::pc_width-1:0] pc0,
  output logic [fetch_pkg::pc_width-1:0] pc1,
  output fetch_pkg::instr_word_u instr0,
  output fetch_pkg::instr_word_u instr1
);

  localparam int idx_width = $clog2(buffer_depth);
  localparam int cnt_width = idx_width + 2; // room for a full queue plus one word.
  localparam int stall_level = buffer_depth / 2;
  localparam int parcels = fetch_pkg::fetch_parcels;
  localparam int parcel_bits = $bits(fetch_pkg::parcel_t);

  logic [fetch_pkg::pc_width-1:0] pc_q [buffer_depth];
  fetch_pkg::parcel_t parcel_q [buffer_depth];

  logic [idx_width-1:0] wr_idx;
  logic [idx_width-1:0] rd_idx;
  logic [idx_width:0] count;

  logic accept;
  logic [cnt_width-1:0] avail;
  logic [cnt_width-1:0] count_next;

  logic [fetch_pkg::pc_width-1:0] e_pc [parcels];
  fetch_pkg::parcel_t e_parcel [parcels];
  logic [parcels-1:0] comp;

  logic ok0;
  logic ok1;
  logic [1:0] len0;
  logic [1:0] len1;
  logic [1:0] start1;
  logic [2:0] take;
  logic [fetch_pkg::pc_width-1:0] pc0_raw;
  logic [fetch_pkg::pc_width-1:0] pc1_raw;
  fetch_pkg::instr_word_u word0;
  fetch_pkg::instr_word_u word1;

  // a redirect in the same cycle makes the response stale.
  assign accept = fetch.ready & ~fetch.clear;

  assign avail = fetch.clear ? '0 :
                 cnt_width'(count) + (accept ? cnt_width'(parcels) : cnt_width'(0));

  // the first four parcels at the read index, with the incoming word just behind the queue.
  always_comb begin
    for (int k = 0; k < parcels; k++) begin
      if (k < int'(count)) begin
        e_pc[k] = pc_q[rd_idx + idx_width'(k)];
        e_parcel[k] = parcel_q[rd_idx + idx_width'(k)];
      end else begin
        e_pc[k] = fetch.pc +
                  fetch_pkg::pc_width'((k - int'(count)) * fetch_pkg::parcel_bytes);
        e_parcel[k] = fetch.rdata[parcel_bits * (k - int'(count)) +: parcel_bits];
      end
      comp[k] = e_parcel[k][1:0] != 2'b11; // compressed unless the low bits are 11.
    end
  end

  always_comb begin
    ok0 = 1'b0;
    ok1 = 1'b0;
    len0 = 2'd0;
    len1 = 2'd0;
    word0 = '0;
    word1 = '0;
    pc0_raw = e_pc[0];
    if (avail >= cnt_width'(1)) begin
      word0.parcels.lo = e_parcel[0];
      if (comp[0]) begin
        ok0 = 1'b1;
        len0 = 2'd1;
      end else if (avail >= cnt_width'(2)) begin
        ok0 = 1'b1;
        len0 = 2'd2;
        word0.parcels.hi = e_parcel[1];
      end
    end
    start1 = ok0 ? len0 : 2'd0; // slot 1 starts right after slot 0.
    pc1_raw = e_pc[start1];
    if (ok0 && avail > cnt_width'(start1)) begin
      word1.parcels.lo = e_parcel[start1];
      if (comp[start1]) begin
        ok1 = 1'b1;
        len1 = 2'd1;
      end else if (avail > cnt_width'(start1) + cnt_width'(1)) begin
        ok1 = 1'b1;
        len1 = 2'd2;
        word1.parcels.hi = e_parcel[start1 + 2'd1];
      end
    end
    if (issue_stall) begin
      ok0 = 1'b0;
      ok1 = 1'b0;
    end
    take = (ok0 ? {1'b0, len0} : 3'd0) + (ok1 ? {1'b0, len1} : 3'd0);
  end

  assign count_next = avail - cnt_width'(take);

  // raised one word early, since one request can still be in flight.
  assign fetch.stall = count_next > cnt_width'(stall_level);

  assign ready0 = ok0;
  assign ready1 = ok1;
  assign pc0 = ok0 ? pc0_raw : fetch_pkg::no_pc;
  assign pc1 = ok1 ? pc1_raw : fetch_pkg::no_pc;
  assign instr0 = ok0 ? word0 : '0;
  assign instr1 = ok1 ? word1 : '0;

  always_ff @(posedge clock) begin
    if (accept) begin
      for (int k = 0; k < parcels; k++) begin
        pc_q[wr_idx + idx_width'(k)] <=
          fetch.pc + fetch_pkg::pc_width'(k * fetch_pkg::parcel_bytes);
        parcel_q[wr_idx + idx_width'(k)] <= fetch.rdata[parcel_bits * k +: parcel_bits];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count <= '0;
    end else if (fetch.clear) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count <= '0;
    end else begin
      if (accept) begin
        wr_idx <= wr_idx + idx_width'(parcels);
      end
      rd_idx <= rd_idx + idx_width'(take);
      count <= count_next[idx_width:0];
    end
  end

endmodule

// File: logic/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;

  logic req; // one-cycle fetch request.
  logic [fetch_pkg::pc_width-1:0] pc_req;
  logic ready; // response strobe, one cycle after req.
  logic [fetch_pkg::pc_width-1:0] pc;
  logic [fetch_pkg::fetch_width-1:0] rdata;
  logic clear; // redirect, drops everything queued.
  logic stall; // the queue is more than half full.

  modport seq (
    output req,
    output pc_req,
    output clear,
    input stall
  );

  modport mem (
    input req,
    input pc_req,
    output ready,
    output pc,
    output rdata
  );

  modport buffer (
    input ready,
    input pc,
    input rdata,
    input clear,
    output stall
  );

endinterface

// File: logic/fetch_pkg.sv
package fetch_pkg;

  localparam int fetch_width = 64; // one fetch word holds four parcels.
  localparam int pc_width = 32;
  localparam int mem_words = 64;
  localparam int mem_addr_width = 6;

  typedef logic [15:0] parcel_t;

  localparam int parcel_bytes = $bits(parcel_t) / 8;
  localparam int fetch_parcels = fetch_width / $bits(parcel_t);

  // a 32-bit instruction is assembled from two parcels, the first one in the low half.
  typedef struct packed {
    parcel_t hi;
    parcel_t lo;
  } parcel_pair_t;

  typedef union packed {
    parcel_pair_t parcels;
    logic [31:0] raw;
  } instr_word_u;

  localparam logic [pc_width-1:0] no_pc = {pc_width{1'b1}}; // pc shown on an idle slot.

endpackage

// File: logic/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
  input logic clock,
  input logic reset,
  input logic run,
  input logic redirect,
  input logic [fetch_pkg::pc_width-1:0] redirect_pc,
  fetch_if.seq fetch
);

  localparam int fetch_bytes = fetch_pkg::fetch_width / 8;

  logic [fetch_pkg::pc_width-1:0] fetch_pc; // next word to request.
  logic issue;

  // a fetch goes out whenever the core runs and the buffer has room.
  assign issue = run & ~fetch.stall;

  assign fetch.req = issue;
  assign fetch.clear = redirect;

  // the redirect target is used at once, so no cycle is lost on a taken redirect.
  assign fetch.pc_req = redirect ? redirect_pc : fetch_pc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      fetch_pc <= '0;
    end else if (issue) begin
      fetch_pc <= fetch.pc_req + fetch_pkg::pc_width'(fetch_bytes);
    end else if (redirect) begin
      fetch_pc <= redirect_pc; // held until the buffer drains or run rises.
    end
  end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int buffer_depth = 16
) (
  input logic clock,
  input logic reset,
  input logic run,
  input logic redirect,
  input logic [fetch_pkg::pc_width-1:0] redirect_pc,
  input logic issue_stall,
  input logic load_valid,
  input logic [fetch_pkg::mem_addr_width-1:0] load_addr,
  input logic [fetch_pkg::fetch_width-1:0] load_data,
  output logic ready0,
  output logic ready1,
  output logic [fetch_pkg::pc_width-1:0] pc0,
  output logic [fetch_pkg::pc_width-1:0] pc1,
  output fetch_pkg::instr_word_u instr0,
  output fetch_pkg::instr_word_u instr1
);

  fetch_if fetch ();

  fetch_sequencer sequencer (
    .clock(clock),
    .reset(reset),
    .run(run),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .fetch(fetch.seq)
  );

  instr_mem memory (
    .clock(clock),
    .reset(reset),
    .load_valid(load_valid),
    .load_addr(load_addr),
    .load_data(load_data),
    .fetch(fetch.mem)
  );

  // the aligner issues up to two instructions per cycle.
  fetch_buffer #(
    .buffer_depth(buffer_depth)
  ) aligner (
    .clock(clock),
    .reset(reset),
    .fetch(fetch.buffer),
    .issue_stall(issue_stall),
    .ready0(ready0),
    .ready1(ready1),
    .pc0(pc0),
    .pc1(pc1),
    .instr0(instr0),
    .instr1(instr1)
  );

endmodule

// File: logic/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
  input logic clock,
  input logic reset,
  input logic load_valid,
  input logic [fetch_pkg::mem_addr_width-1:0] load_addr,
  input logic [fetch_pkg::fetch_width-1:0] load_data,
  fetch_if.mem fetch
);

  localparam int offset_bits = $clog2(fetch_pkg::fetch_width / 8);
  localparam int index_top = fetch_pkg::mem_addr_width + offset_bits - 1;

  logic [fetch_pkg::fetch_width-1:0] words [fetch_pkg::mem_words];
  logic [fetch_pkg::mem_addr_width-1:0] read_index;

  assign read_index = fetch.pc_req[index_top:offset_bits]; // pc bits 8 down to 3.

  always_ff @(posedge clock) begin
    if (load_valid) begin
      words[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch.req) begin
      fetch.rdata <= words[read_index];
      fetch.pc <= fetch.pc_req; // the response carries its own pc.
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      fetch.ready <= 1'b0;
    end else begin
      fetch.ready <= fetch.req;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the fetch unit testbench with Verilator and runs it.
# The exit status is the simulator's, so a failing run returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  --top-module fetch_unit_tb \
  -f all.f \
  -Mdir obj_dir \
  -o fetch_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/fetch_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
